//--- hdl/tile_pkg.sv
// Shared widths, address map and route types for the accelerator tile memory side
package tile_pkg;

  // Bus widths
  localparam int unsigned ADDR_W     = 32;             // Byte address width
  localparam int unsigned DATA_W     = 32;             // Data width of every port
  localparam int unsigned BE_W       = DATA_W / 8;     // One strobe per byte lane
  localparam int unsigned BYTE_OFF_W = $clog2(BE_W);   // Byte offset bits inside a word

  typedef logic [ADDR_W-1:0] addr_t;  // Byte address
  typedef logic [DATA_W-1:0] data_t;  // Read/write data word
  typedef logic [BE_W-1:0]   be_t;    // Byte enables

  // Address map
  // L1 end depends on bank count and depth, so the decoder derives it
  localparam addr_t L1_BASE = 32'h1000_0000;  // First byte of the scratchpad
  localparam addr_t L2_BASE = 32'h8000_0000;  // First byte of external L2
  localparam addr_t L2_END  = 32'h8FFF_FFFF;  // Last byte of external L2, inclusive

  // Route taken by a core request
  typedef enum logic [1:0] {
    TGT_L1,   // Local scratchpad through the bank crossbar
    TGT_L2,   // External bus through the bridge
    TGT_ERR   // Unmapped, answered locally with err
  } target_e;

endpackage

//--- hdl/spm_bank.sv
`timescale 1ns/100ps
// Single scratchpad SRAM bank with byte-lane writes and registered reads
module spm_bank import tile_pkg::*; #(
  parameter int unsigned N_WORDS = 64                  // Depth in words
) (
  input  logic                       clk_i,
  input  logic                       req_i,            // Access this cycle
  input  logic                       we_i,             // 1 = write, 0 = read
  input  be_t                        be_i,             // Byte lanes to write
  input  logic [$clog2(N_WORDS)-1:0] row_i,            // Word row inside the bank
  input  data_t                      wdata_i,
  output data_t                      rdata_o           // Valid the cycle after a read
);

  data_t mem_q [N_WORDS] = '{default: '0};             // Storage, starts cleared
  data_t rdata_q;                                      // Read output register

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int i = 0; i < BE_W; i++) begin
          if (be_i[i]) begin
            mem_q[row_i][8*i +: 8] <= wdata_i[8*i +: 8];  // Merge selected lane only
          end
        end
      end else begin
        rdata_q <= mem_q[row_i];                       // One-cycle read latency
      end
    end
  end

  // Holds last read word until the next read
  assign rdata_o = rdata_q;

endmodule

//--- hdl/l2_bridge.sv
`timescale 1ns/100ps
// Core-to-L2 bridge that keeps at most one transaction open on the external bus
module l2_bridge import tile_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,

  // Upstream from the address decoder
  input  logic  l2c_req_i,
  input  addr_t l2c_addr_i,
  input  logic  l2c_we_i,
  input  be_t   l2c_be_i,
  input  data_t l2c_wdata_i,
  output logic  l2c_gnt_o,
  output logic  l2c_rvalid_o,
  output data_t l2c_rdata_o,
  output logic  l2c_err_o,

  // External L2 bus
  output logic  l2_req_o,
  output addr_t l2_addr_o,
  output logic  l2_we_o,
  output be_t   l2_be_o,
  output data_t l2_wdata_o,
  input  logic  l2_gnt_i,
  input  logic  l2_rvalid_i,
  input  data_t l2_rdata_i,
  input  logic  l2_err_i
);

  logic busy_q;                                        // A granted access awaits rvalid

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (l2_req_o && l2_gnt_i) begin
      busy_q <= 1'b1;                                  // Opened on handshake
    end else if (l2_rvalid_i) begin
      busy_q <= 1'b0;                                  // Closed by the response
    end
  end

  assign l2_req_o   = l2c_req_i && !busy_q;            // Hold off while one is open
  assign l2_addr_o  = l2c_addr_i;
  assign l2_we_o    = l2c_we_i;
  assign l2_be_o    = l2c_be_i;
  assign l2_wdata_o = l2c_wdata_i;

  assign l2c_gnt_o    = l2_req_o && l2_gnt_i;          // Grant only when actually forwarded
  assign l2c_rvalid_o = l2_rvalid_i;                   // Response comes straight back
  assign l2c_rdata_o  = l2_rdata_i;
  assign l2c_err_o    = l2_err_i;

endmodule

//--- hdl/spm_xbar.sv
`timescale 1ns/100ps
// Word-interleaved bank crossbar with per-bank round-robin between core and accelerator
module spm_xbar import tile_pkg::*; #(
  parameter int unsigned N_MEM_BANKS  = 4,             // Power of two
  parameter int unsigned N_WORDS_BANK = 64             // Power of two
) (
  input  logic  clk_i,
  input  logic  rst_ni,

  // Core L1 path from the decoder
  input  logic  l1_req_i,
  input  addr_t l1_addr_i,
  input  logic  l1_we_i,
  input  be_t   l1_be_i,
  input  data_t l1_wdata_i,
  output logic  l1_gnt_o,
  output logic  l1_rvalid_o,
  output data_t l1_rdata_o,

  // Accelerator memory port
  input  logic  acc_req_i,
  input  addr_t acc_addr_i,
  input  logic  acc_we_i,
  input  be_t   acc_be_i,
  input  data_t acc_wdata_i,
  output logic  acc_gnt_o,
  output logic  acc_rvalid_o,
  output data_t acc_rdata_o,

  // Bank side
  output logic  [N_MEM_BANKS-1:0]                            bank_req_o,
  output logic  [N_MEM_BANKS-1:0]                            bank_we_o,
  output be_t   [N_MEM_BANKS-1:0]                            bank_be_o,
  output logic  [N_MEM_BANKS-1:0][$clog2(N_WORDS_BANK)-1:0] bank_row_o,
  output data_t [N_MEM_BANKS-1:0]                            bank_wdata_o,
  input  data_t [N_MEM_BANKS-1:0]                            bank_rdata_i
);

  localparam int unsigned BANK_W = $clog2(N_MEM_BANKS);
  localparam int unsigned ROW_W  = $clog2(N_WORDS_BANK);

  typedef logic [BANK_W-1:0] bank_idx_t;
  typedef logic [ROW_W-1:0]  row_t;

  bank_idx_t              l1_bank, acc_bank;           // Word address mod banks
  bank_idx_t              l1_bank_q, acc_bank_q;       // Bank of the access in flight
  row_t                   l1_row, acc_row;             // Word address div banks
  logic                   conflict;                    // Both ports on one bank
  logic [N_MEM_BANKS-1:0] prio_q;                      // 0 core first, 1 accelerator first
  logic                   l1_rvalid_q, acc_rvalid_q;
  logic                   l1_we_q, acc_we_q;           // Writes answer with zero data

  assign l1_bank  = l1_addr_i[BYTE_OFF_W +: BANK_W];   // Low word bits interleave banks
  assign l1_row   = l1_addr_i[BYTE_OFF_W + BANK_W +: ROW_W];
  assign acc_bank = acc_addr_i[BYTE_OFF_W +: BANK_W];
  assign acc_row  = acc_addr_i[BYTE_OFF_W + BANK_W +: ROW_W];

  assign conflict  = l1_req_i && acc_req_i && (l1_bank == acc_bank);
  assign l1_gnt_o  = l1_req_i && (!conflict || !prio_q[l1_bank]);
  assign acc_gnt_o = acc_req_i && (!conflict || prio_q[acc_bank]);

  // Steer the granted port onto each bank
  always_comb begin
    for (int b = 0; b < N_MEM_BANKS; b++) begin
      bank_req_o[b]   = 1'b0;
      bank_we_o[b]    = 1'b0;
      bank_be_o[b]    = '0;
      bank_row_o[b]   = '0;
      bank_wdata_o[b] = '0;
      if (l1_gnt_o && (l1_bank == bank_idx_t'(b))) begin
        bank_req_o[b]   = 1'b1;
        bank_we_o[b]    = l1_we_i;
        bank_be_o[b]    = l1_be_i;
        bank_row_o[b]   = l1_row;
        bank_wdata_o[b] = l1_wdata_i;
      end else if (acc_gnt_o && (acc_bank == bank_idx_t'(b))) begin
        bank_req_o[b]   = 1'b1;
        bank_we_o[b]    = acc_we_i;
        bank_be_o[b]    = acc_be_i;
        bank_row_o[b]   = acc_row;
        bank_wdata_o[b] = acc_wdata_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q       <= '0;
      l1_rvalid_q  <= 1'b0;
      acc_rvalid_q <= 1'b0;
    end else begin
      l1_rvalid_q  <= l1_gnt_o;                        // Bank answers next cycle
      acc_rvalid_q <= acc_gnt_o;
      if (conflict) begin
        prio_q[l1_bank] <= !prio_q[l1_bank];           // Loser wins the next clash
      end
    end
  end

  // Response steering info, only meaningful with rvalid
  always_ff @(posedge clk_i) begin
    if (l1_gnt_o) begin
      l1_bank_q <= l1_bank;
      l1_we_q   <= l1_we_i;
    end
    if (acc_gnt_o) begin
      acc_bank_q <= acc_bank;
      acc_we_q   <= acc_we_i;
    end
  end

  assign l1_rvalid_o  = l1_rvalid_q;
  assign l1_rdata_o   = l1_we_q ? '0 : bank_rdata_i[l1_bank_q];
  assign acc_rvalid_o = acc_rvalid_q;
  assign acc_rdata_o  = acc_we_q ? '0 : bank_rdata_i[acc_bank_q];

endmodule

//--- hdl/tile_addr_demux.sv
`timescale 1ns/100ps
// Core address decoder routing to L1, L2 or an error responder with in-order responses
module tile_addr_demux import tile_pkg::*; #(
  parameter int unsigned N_MEM_BANKS  = 4,
  parameter int unsigned N_WORDS_BANK = 64,
  parameter int unsigned N_MAX_TRAN   = 2              // Max accesses in flight
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  tile_enable_i,                         // Level, sampled each cycle

  // Core data port
  input  logic  core_req_i,
  input  addr_t core_addr_i,
  input  logic  core_we_i,
  input  be_t   core_be_i,
  input  data_t core_wdata_i,
  output logic  core_gnt_o,
  output logic  core_rvalid_o,
  output data_t core_rdata_o,
  output logic  core_err_o,

  // L1 path into the bank crossbar
  output logic  l1_req_o,
  output addr_t l1_addr_o,
  output logic  l1_we_o,
  output be_t   l1_be_o,
  output data_t l1_wdata_o,
  input  logic  l1_gnt_i,
  input  logic  l1_rvalid_i,
  input  data_t l1_rdata_i,

  // L2 path into the bridge
  output logic  l2c_req_o,
  output addr_t l2c_addr_o,
  output logic  l2c_we_o,
  output be_t   l2c_be_o,
  output data_t l2c_wdata_o,
  input  logic  l2c_gnt_i,
  input  logic  l2c_rvalid_i,
  input  data_t l2c_rdata_i,
  input  logic  l2c_err_i
);

  localparam addr_t       L1_END = L1_BASE + addr_t'(N_MEM_BANKS * N_WORDS_BANK * BE_W);
  localparam int unsigned CNT_W  = $clog2(N_MAX_TRAN + 1);

  logic             enable_q;                          // Registered tile enable
  target_e          tgt;                               // Route of the current request
  target_e          last_tgt_q;                        // Route of accesses in flight
  logic [CNT_W-1:0] cnt_q;                             // Accesses awaiting rvalid
  logic             can_issue;
  logic             err_gnt;                           // Unmapped access accepted
  logic             err_valid_q;                       // Error response pulse
  logic             resp_valid;

  always_comb begin
    if ((core_addr_i >= L1_BASE) && (core_addr_i < L1_END)) begin
      tgt = TGT_L1;
    end else if ((core_addr_i >= L2_BASE) && (core_addr_i <= L2_END)) begin
      tgt = TGT_L2;
    end else begin
      tgt = TGT_ERR;
    end
  end

  // Same route only, so returns cannot overtake each other
  assign can_issue = enable_q && (cnt_q < CNT_W'(N_MAX_TRAN)) &&
                     ((cnt_q == '0) || (tgt == last_tgt_q));

  assign l1_req_o   = core_req_i && can_issue && (tgt == TGT_L1);
  assign l2c_req_o  = core_req_i && can_issue && (tgt == TGT_L2);
  assign err_gnt    = core_req_i && can_issue && (tgt == TGT_ERR);  // Always accepted
  assign core_gnt_o = (l1_req_o && l1_gnt_i) || (l2c_req_o && l2c_gnt_i) || err_gnt;

  // Payload fans out to both paths, req picks the one that acts
  assign l1_addr_o   = core_addr_i;
  assign l1_we_o     = core_we_i;
  assign l1_be_o     = core_be_i;
  assign l1_wdata_o  = core_wdata_i;
  assign l2c_addr_o  = core_addr_i;
  assign l2c_we_o    = core_we_i;
  assign l2c_be_o    = core_be_i;
  assign l2c_wdata_o = core_wdata_i;

  // Response mux follows the route of the accesses in flight
  always_comb begin
    case (last_tgt_q)
      TGT_L1: begin
        resp_valid   = l1_rvalid_i;
        core_rdata_o = l1_rdata_i;
        core_err_o   = 1'b0;
      end
      TGT_L2: begin
        resp_valid   = l2c_rvalid_i;                   // Same-cycle echo of the L2 bus
        core_rdata_o = l2c_rdata_i;
        core_err_o   = l2c_err_i;
      end
      default: begin
        resp_valid   = err_valid_q;
        core_rdata_o = '0;                             // Unmapped reads return zero
        core_err_o   = err_valid_q;
      end
    endcase
  end

  assign core_rvalid_o = resp_valid && (cnt_q != '0);  // No stray responses when idle

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q    <= 1'b0;
      last_tgt_q  <= TGT_L1;
      cnt_q       <= '0;
      err_valid_q <= 1'b0;
    end else begin
      enable_q    <= tile_enable_i;                    // Takes effect one cycle later
      err_valid_q <= err_gnt;                          // Answer one cycle after gnt
      if (core_gnt_o) begin
        last_tgt_q <= tgt;
      end
      if (core_gnt_o && !core_rvalid_o) begin
        cnt_q <= cnt_q + CNT_W'(1);
      end else if (!core_gnt_o && core_rvalid_o) begin
        cnt_q <= cnt_q - CNT_W'(1);
      end
    end
  end

endmodule

//--- hdl/tile_top.sv
`timescale 1ns/100ps
// Accelerator tile memory side: core decoder, shared L1 scratchpad and L2 bridge
module tile_top import tile_pkg::*; #(
  parameter int unsigned N_MEM_BANKS  = 4,             // Interleaved L1 banks
  parameter int unsigned N_WORDS_BANK = 64,            // Words in each bank
  parameter int unsigned N_MAX_TRAN   = 2              // Core accesses in flight
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  tile_enable_i,

  // Core data port
  input  logic  core_req_i,
  input  addr_t core_addr_i,
  input  logic  core_we_i,
  input  be_t   core_be_i,
  input  data_t core_wdata_i,
  output logic  core_gnt_o,
  output logic  core_rvalid_o,
  output data_t core_rdata_o,
  output logic  core_err_o,

  // Accelerator memory port, L1 only
  input  logic  acc_req_i,
  input  addr_t acc_addr_i,
  input  logic  acc_we_i,
  input  be_t   acc_be_i,
  input  data_t acc_wdata_i,
  output logic  acc_gnt_o,
  output logic  acc_rvalid_o,
  output data_t acc_rdata_o,

  // External L2 bus
  output logic  l2_req_o,
  output addr_t l2_addr_o,
  output logic  l2_we_o,
  output be_t   l2_be_o,
  output data_t l2_wdata_o,
  input  logic  l2_gnt_i,
  input  logic  l2_rvalid_i,
  input  data_t l2_rdata_i,
  input  logic  l2_err_i
);

  localparam int unsigned ROW_W = $clog2(N_WORDS_BANK);

  // Decoder to crossbar
  logic  l1_req, l1_we, l1_gnt, l1_rvalid;
  addr_t l1_addr;
  be_t   l1_be;
  data_t l1_wdata, l1_rdata;

  // Decoder to bridge
  logic  l2c_req, l2c_we, l2c_gnt, l2c_rvalid, l2c_err;
  addr_t l2c_addr;
  be_t   l2c_be;
  data_t l2c_wdata, l2c_rdata;

  // Crossbar to banks
  logic  [N_MEM_BANKS-1:0]            bank_req, bank_we;
  be_t   [N_MEM_BANKS-1:0]            bank_be;
  logic  [N_MEM_BANKS-1:0][ROW_W-1:0] bank_row;
  data_t [N_MEM_BANKS-1:0]            bank_wdata, bank_rdata;

  tile_addr_demux #(
    .N_MEM_BANKS  (N_MEM_BANKS),
    .N_WORDS_BANK (N_WORDS_BANK),
    .N_MAX_TRAN   (N_MAX_TRAN)
  ) i_demux (
    .clk_i, .rst_ni, .tile_enable_i,
    .core_req_i, .core_addr_i, .core_we_i, .core_be_i, .core_wdata_i,
    .core_gnt_o, .core_rvalid_o, .core_rdata_o, .core_err_o,
    .l1_req_o    (l1_req),    .l1_addr_o   (l1_addr),   .l1_we_o     (l1_we),
    .l1_be_o     (l1_be),     .l1_wdata_o  (l1_wdata),  .l1_gnt_i    (l1_gnt),
    .l1_rvalid_i (l1_rvalid), .l1_rdata_i  (l1_rdata),
    .l2c_req_o   (l2c_req),   .l2c_addr_o  (l2c_addr),  .l2c_we_o    (l2c_we),
    .l2c_be_o    (l2c_be),    .l2c_wdata_o (l2c_wdata), .l2c_gnt_i   (l2c_gnt),
    .l2c_rvalid_i(l2c_rvalid), .l2c_rdata_i(l2c_rdata), .l2c_err_i   (l2c_err)
  );

  spm_xbar #(
    .N_MEM_BANKS  (N_MEM_BANKS),
    .N_WORDS_BANK (N_WORDS_BANK)
  ) i_xbar (
    .clk_i, .rst_ni,
    .l1_req_i    (l1_req),    .l1_addr_i  (l1_addr),  .l1_we_i    (l1_we),
    .l1_be_i     (l1_be),     .l1_wdata_i (l1_wdata), .l1_gnt_o   (l1_gnt),
    .l1_rvalid_o (l1_rvalid), .l1_rdata_o (l1_rdata),
    .acc_req_i, .acc_addr_i, .acc_we_i, .acc_be_i, .acc_wdata_i,
    .acc_gnt_o, .acc_rvalid_o, .acc_rdata_o,
    .bank_req_o  (bank_req),  .bank_we_o  (bank_we),  .bank_be_o  (bank_be),
    .bank_row_o  (bank_row),  .bank_wdata_o (bank_wdata), .bank_rdata_i (bank_rdata)
  );

  for (genvar b = 0; b < N_MEM_BANKS; b++) begin : g_bank
    spm_bank #(
      .N_WORDS (N_WORDS_BANK)
    ) i_bank (
      .clk_i,
      .req_i   (bank_req[b]),
      .we_i    (bank_we[b]),
      .be_i    (bank_be[b]),
      .row_i   (bank_row[b]),
      .wdata_i (bank_wdata[b]),
      .rdata_o (bank_rdata[b])
    );
  end

  l2_bridge i_l2_bridge (
    .clk_i, .rst_ni,
    .l2c_req_i    (l2c_req),    .l2c_addr_i  (l2c_addr),  .l2c_we_i    (l2c_we),
    .l2c_be_i     (l2c_be),     .l2c_wdata_i (l2c_wdata), .l2c_gnt_o   (l2c_gnt),
    .l2c_rvalid_o (l2c_rvalid), .l2c_rdata_o (l2c_rdata), .l2c_err_o   (l2c_err),
    .l2_req_o, .l2_addr_o, .l2_we_o, .l2_be_o, .l2_wdata_o,
    .l2_gnt_i, .l2_rvalid_i, .l2_rdata_i, .l2_err_i
  );

endmodule

//--- testbench/tb_tile.sv
`timescale 1ns/100ps
// Directed testbench for the tile memory side with an L2 bus model and in-order response checks
module tb_tile import tile_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 60 * 50;             // ~60 accesses, each far below 50 cycles

  logic  clk_i, rst_ni, tile_enable_i;
  logic  core_req_i, core_we_i, core_gnt_o, core_rvalid_o, core_err_o;
  addr_t core_addr_i;
  be_t   core_be_i;
  data_t core_wdata_i, core_rdata_o;
  logic  acc_req_i, acc_we_i, acc_gnt_o, acc_rvalid_o;
  addr_t acc_addr_i;
  be_t   acc_be_i;
  data_t acc_wdata_i, acc_rdata_o;
  logic  l2_req_o, l2_we_o, l2_gnt_i, l2_rvalid_i, l2_err_i;
  addr_t l2_addr_o;
  be_t   l2_be_o;
  data_t l2_wdata_o, l2_rdata_i;

  int    cyc = 0;                                      // Rising edges since start
  int    seed = 92;                                    // L2 model delays
  int    core_wait, acc_wait;                          // Cycles spent before gnt
  logic  l2_pending = 1'b0;                            // Model holds an open transaction
  logic  l2_req_seen = 1'b0;
  addr_t l2_last_addr;                                 // Fields of the last L2 handshake
  logic  l2_last_we;
  be_t   l2_last_be;
  data_t l2_last_wdata;
  data_t l2_mem [addr_t];                              // L2 model storage
  data_t l1_model [addr_t];                            // Expected scratchpad contents
  data_t exp_data_q [$];                               // Expected core responses, issue order
  logic  exp_err_q [$];
  int    exp_lat_q [$];                                // 0 means any latency (L2)
  int    gnt_cyc_q [$];

  tile_top #(
    .N_MEM_BANKS  (4),
    .N_WORDS_BANK (64),
    .N_MAX_TRAN   (2)
  ) uut (.*);

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;                           // 20 ns period

  always @(posedge clk_i) begin
    cyc = cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("Timeout: no progress after %0d cycles, a handshake never completed", cyc);
      $display("Checks failed");
      $fatal(1, "Run stopped by timeout");
    end
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  function automatic data_t merge_be(data_t old_w, data_t new_w, be_t be);
    data_t res;
    res = old_w;
    for (int i = 0; i < BE_W; i++) begin
      if (be[i]) res[8*i +: 8] = new_w[8*i +: 8];    // Only enabled lanes change
    end
    return res;
  endfunction

  // Unwritten L2 words read back as a pattern of their full address
  function automatic data_t l2_fill(addr_t a);
    return {a[15:0], ~a[31:16]} ^ 32'h5A5A_0F0F;
  endfunction

  function automatic data_t l1_expect(addr_t a);
    return l1_model.exists(a) ? l1_model[a] : '0;    // Banks start cleared
  endfunction

  // Bus monitor, sampled mid-cycle
  always @(negedge clk_i) begin
    if (l2_req_o) l2_req_seen = 1'b1;
    check("l2_req_o while an L2 transaction is open", 32'(l2_pending && l2_req_o), 0);
  end

  // L2 memory model: gnt after 0-3 idle cycles, rvalid 1-3 cycles after gnt
  initial begin : l2_model
    int    d;
    int    r;
    data_t rd;
    forever begin
      @(negedge clk_i);
      if (l2_req_o) begin
        d = {$random(seed)} % 4;
        r = {$random(seed)} % 3;
        repeat (d) @(posedge clk_i);
        @(posedge clk_i);
        l2_gnt_i <= 1'b1;
        @(negedge clk_i);
        check("l2_req_o held until gnt", 32'(l2_req_o), 1);
        l2_last_addr  = l2_addr_o;
        l2_last_we    = l2_we_o;
        l2_last_be    = l2_be_o;
        l2_last_wdata = l2_wdata_o;
        @(posedge clk_i);                              // Handshake edge
        l2_gnt_i   <= 1'b0;
        l2_pending  = 1'b1;
        rd = l2_mem.exists(l2_last_addr) ? l2_mem[l2_last_addr] : l2_fill(l2_last_addr);
        if (l2_last_we) begin
          l2_mem[l2_last_addr] = merge_be(rd, l2_last_wdata, l2_last_be);
          rd = '0;                                     // Writes answer with zero
        end
        repeat (r) @(posedge clk_i);
        l2_rvalid_i <= 1'b1;
        l2_rdata_i  <= rd;
        @(posedge clk_i);
        l2_rvalid_i <= 1'b0;
        l2_rdata_i  <= '0;
        l2_pending   = 1'b0;
      end
    end
  end

  // Drives one core request until gnt and queues its expected response
  task automatic core_issue(input addr_t a, input logic we, input be_t be, input data_t wd,
                            input data_t exp_d, input logic exp_e, input int lat);
    core_req_i   <= 1'b1;
    core_addr_i  <= a;
    core_we_i    <= we;
    core_be_i    <= be;
    core_wdata_i <= wd;
    core_wait = 0;
    @(negedge clk_i);
    while (!core_gnt_o) begin
      @(posedge clk_i);
      @(negedge clk_i);
      core_wait++;
    end
    exp_data_q.push_back(exp_d);
    exp_err_q.push_back(exp_e);
    exp_lat_q.push_back(lat);
    gnt_cyc_q.push_back(cyc);
    @(posedge clk_i);
    core_req_i <= 1'b0;                                // Next issue may raise it again
  endtask

  task automatic core_collect(input int n);
    int g;
    int lat;
    repeat (n) begin
      @(negedge clk_i);
      while (!core_rvalid_o) @(negedge clk_i);
      check("core rvalid with no request pending", 32'(gnt_cyc_q.size() == 0), 0);
      g   = gnt_cyc_q.pop_front();
      lat = exp_lat_q.pop_front();
      check("core_rdata_o", core_rdata_o, exp_data_q.pop_front());
      check("core_err_o", 32'(core_err_o), 32'(exp_err_q.pop_front()));
      if (lat > 0) begin
        check("core rvalid cycles after gnt", cyc - g, lat);
      end else begin
        check("core rvalid later than gnt", 32'(cyc > g), 1);
        check("l2_rvalid_i in the core rvalid cycle", 32'(l2_rvalid_i), 1);
      end
    end
  endtask

  task automatic core_access(input addr_t a, input logic we, input be_t be, input data_t wd,
                             input data_t exp_d, input logic exp_e, input int lat);
    @(posedge clk_i);
    fork
      core_issue(a, we, be, wd, exp_d, exp_e, lat);
      core_collect(1);
    join
  endtask

  task automatic acc_access(input addr_t a, input logic we, input be_t be, input data_t wd,
                            input data_t exp_d);
    @(posedge clk_i);
    acc_req_i   <= 1'b1;
    acc_addr_i  <= a;
    acc_we_i    <= we;
    acc_be_i    <= be;
    acc_wdata_i <= wd;
    acc_wait = 0;
    @(negedge clk_i);
    while (!acc_gnt_o) begin
      @(posedge clk_i);
      @(negedge clk_i);
      acc_wait++;
    end
    @(posedge clk_i);
    acc_req_i <= 1'b0;
    @(negedge clk_i);
    check("acc_rvalid_o one cycle after gnt", 32'(acc_rvalid_o), 1);
    check("acc_rdata_o", acc_rdata_o, exp_d);
  endtask

  task automatic l1_write(input addr_t a, input be_t be, input data_t d);
    l1_model[a] = merge_be(l1_expect(a), d, be);
    core_access(a, 1'b1, be, d, '0, 1'b0, 1);
  endtask

  task automatic l1_read(input addr_t a);
    core_access(a, 1'b0, 4'hf, '0, l1_expect(a), 1'b0, 1);
  endtask

  task automatic test_reset_enable();
    @(negedge clk_i);
    check("core_gnt_o after reset", 32'(core_gnt_o), 0);
    check("core_rvalid_o after reset", 32'(core_rvalid_o), 0);
    check("acc_gnt_o after reset", 32'(acc_gnt_o), 0);
    check("acc_rvalid_o after reset", 32'(acc_rvalid_o), 0);
    check("l2_req_o after reset", 32'(l2_req_o), 0);
    @(posedge clk_i);
    core_req_i  <= 1'b1;                               // Held through the enable change
    core_addr_i <= L1_BASE;
    core_we_i   <= 1'b0;
    core_be_i   <= 4'hf;
    repeat (10) begin
      @(negedge clk_i);
      check("core_gnt_o with tile disabled", 32'(core_gnt_o), 0);
    end
    @(posedge clk_i);
    tile_enable_i <= 1'b1;
    @(negedge clk_i);
    check("core_gnt_o before enable is registered", 32'(core_gnt_o), 0);
    l1_read(L1_BASE);
    check("core gnt wait once enabled", core_wait, 0);
  endtask

  task automatic test_l1_core();
    for (int i = 0; i < 6; i++) begin
      l1_write(L1_BASE + 32'h40 + 4*i, 4'hf, 32'h1100_0000 + 32'h0101_0101*i);
    end
    for (int i = 0; i < 6; i++) begin
      l1_read(L1_BASE + 32'h40 + 4*i);
    end
    l1_write(L1_BASE + 32'h44, 4'b0101, 32'hAABB_CCDD);  // Lanes 0 and 2 only
    l1_read(L1_BASE + 32'h44);
    l1_write(L1_BASE + 32'h48, 4'b1000, 32'h7700_0000);
    l1_read(L1_BASE + 32'h48);
    l1_write(L1_BASE + 32'h3FC, 4'hf, 32'h0BAD_F00D);    // Last L1 word
    l1_read(L1_BASE + 32'h3FC);
  endtask

  task automatic test_acc_shared();
    logic core_won;                                    // Core took the first clash
    l1_model[L1_BASE + 32'h100] = 32'hCAFE_F00D;
    acc_access(L1_BASE + 32'h100, 1'b1, 4'hf, 32'hCAFE_F00D, '0);
    l1_read(L1_BASE + 32'h100);
    acc_access(L1_BASE + 32'h40, 1'b0, 4'hf, '0, l1_expect(L1_BASE + 32'h40));
    // Same bank on both ports, priority flips between the two rounds
    for (int r = 0; r < 2; r++) begin
      l1_model[L1_BASE + 32'h114 + 16*r] = 32'h00AC_0000 + r;
      fork
        l1_read(L1_BASE + 32'h104 + 16*r);
        acc_access(L1_BASE + 32'h114 + 16*r, 1'b1, 4'hf, 32'h00AC_0000 + r, '0);
      join
      check("core gnt within two cycles on a clash", 32'(core_wait <= 1), 1);
      check("acc gnt within two cycles on a clash", 32'(acc_wait <= 1), 1);
      check("ports stalled on a clash", core_wait + acc_wait, 1);  // Bank serves one per cycle
      if (r == 0) begin
        core_won = (core_wait == 0);
      end else begin
        check("clash winner alternates", 32'(core_wait == 0), 32'(!core_won));
      end
    end
  endtask

  task automatic test_l2();
    core_access(L2_BASE + 32'h10, 1'b1, 4'hf, 32'h1234_5678, '0, 1'b0, 0);
    check("l2_addr_o", l2_last_addr, L2_BASE + 32'h10);
    check("l2_we_o", 32'(l2_last_we), 1);
    check("l2_be_o", 32'(l2_last_be), 32'hf);
    check("l2_wdata_o", l2_last_wdata, 32'h1234_5678);
    core_access(L2_BASE + 32'h10, 1'b1, 4'b0011, 32'hFFFF_ABCD, '0, 1'b0, 0);
    check("l2_be_o partial", 32'(l2_last_be), 32'h3);
    core_access(L2_BASE + 32'h10, 1'b0, 4'hf, '0, 32'h1234_ABCD, 1'b0, 0);
    check("l2_we_o on read", 32'(l2_last_we), 0);
    core_access(L2_END - 32'd3, 1'b0, 4'hf, '0, l2_fill(L2_END - 32'd3), 1'b0, 0);
    check("l2_addr_o at L2 end", l2_last_addr, L2_END - 32'd3);
    @(posedge clk_i);
    fork
      begin
        core_issue(L2_BASE + 32'h20, 1'b0, 4'hf, '0, l2_fill(L2_BASE + 32'h20), 1'b0, 0);
        core_issue(L2_BASE + 32'h10, 1'b0, 4'hf, '0, 32'h1234_ABCD, 1'b0, 0);
      end
      core_collect(2);
    join
  endtask

  task automatic test_unmapped();
    l2_req_seen = 1'b0;
    core_access(32'h0000_1000, 1'b0, 4'hf, '0, '0, 1'b1, 1);
    core_access(L1_BASE + 32'h400, 1'b0, 4'hf, '0, '0, 1'b1, 1);  // One past L1
    core_access(32'h9000_0000, 1'b1, 4'hf, 32'hDEAD_BEEF, '0, 1'b1, 1);
    check("l2_req_o raised by an unmapped access", 32'(l2_req_seen), 0);
  endtask

  task automatic test_mixed_order();
    l1_model[L1_BASE + 32'h200] = 32'h5EED_0092;
    @(posedge clk_i);
    fork
      begin
        core_issue(L1_BASE + 32'h200, 1'b1, 4'hf, 32'h5EED_0092, '0, 1'b0, 1);
        core_issue(L2_BASE + 32'h10, 1'b0, 4'hf, '0, 32'h1234_ABCD, 1'b0, 0);
        core_issue(L1_BASE + 32'h200, 1'b0, 4'hf, '0, 32'h5EED_0092, 1'b0, 1);
      end
      core_collect(3);
    join
  endtask

  initial begin
    rst_ni        = 1'b0;
    tile_enable_i = 1'b0;
    core_req_i    = 1'b0;
    core_addr_i   = '0;
    core_we_i     = 1'b0;
    core_be_i     = '0;
    core_wdata_i  = '0;
    acc_req_i     = 1'b0;
    acc_addr_i    = '0;
    acc_we_i      = 1'b0;
    acc_be_i      = '0;
    acc_wdata_i   = '0;
    l2_gnt_i      = 1'b0;
    l2_rvalid_i   = 1'b0;
    l2_rdata_i    = '0;
    l2_err_i      = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_reset_enable();
    test_l1_core();
    test_acc_shared();
    test_l2();
    test_unmapped();
    test_mixed_order();
    repeat (2) @(posedge clk_i);
    $display("All checks passed");
    $finish;
  end

endmodule

//--- src.f
hdl/tile_pkg.sv
hdl/spm_bank.sv
hdl/l2_bridge.sv
hdl/spm_xbar.sv
hdl/tile_addr_demux.sv
hdl/tile_top.sv
testbench/tb_tile.sv

//--- run.sh
#!/bin/sh
# Build the tile testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_tile -f src.f -Mdir obj_dir -o tb_tile
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_tile > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0
